/* scope_golden.txt */
# W addr data | R addr expected | S count first step | O count first step (expected sto)
# E ext mask | I irq_trg irq_stp seen | T trigger stamp readback; all fields hex
R 00 00000008
R 64 00000001
W 08 000000ff
R 08 0000000f
W 10 ffffffff
R 10 0001ffff
W 50 ffffffff
R 50 00003fff
W 44 12345678
R 44 00000000
# decimate by 4, no trigger source so WAIT keeps forwarding
W 08 00000000
W 10 00000000
W 64 00000004
W 60 00000000
W 00 00000001
W 00 00000004
S 8 0100 0001
O 2 0100 0004
W 68 00000002
W 60 00000001
S 8 3ff0 0003
O 2 3ff4 000c
# stop while waiting, stream must stay quiet
W 00 00000008
I 0 1
S 4 0200 0001
W 60 00000000
W 64 00000001
# software trigger, pre 3 post 5
W 08 00000001
W 10 00000003
W 14 00000005
W 00 00000004
S 3 0010 0001
W 00 00000002
S 5 0020 0001
S 3 0030 0001
O 3 0010 0001
O 5 0020 0001
I 1 1
R 18 00000003
R 1c 00000005
R 00 0000000a
# rising edge, level 0x40 hysteresis 0x10, pre 2 post 3
W 08 00000002
W 50 00000040
W 54 00000010
W 58 00000000
W 10 00000002
W 14 00000003
W 00 00000001
W 00 00000004
S 6 0050 3ff8
S 6 0038 0008
O 6 0050 3ff8
O 6 0038 0008
I 1 1
R 1c 00000003
R 00 0000000a
# external line 0, masked off first
W 08 00000000
W 10 00000000
W 14 00000002
W 00 00000004
E 1
R 00 00000004
W 08 00000004
E 1
I 1 0
S 2 0123 0001
O 2 0123 0001
I 0 1
T
R 00 0000000a

/* filelist.f */
+incdir+.
scope_bus_pkg.sv
scope_dsp_pkg.sv
scope_regs.sv
scope_dec_avg.sv
scope_edge.sv
scope_acq.sv
scope_top.sv
scope_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module scope_tb -f filelist.f
./obj_dir/Vscope_tb

/* scope_tb.sv */
`include "scope_params.svh"

module scope_tb
  import scope_bus_pkg::*;
  import scope_dsp_pkg::*;
;

  logic         bus;
  logic         rst_n;
  axil_aw_t     aw;
  logic         awready;
  axil_w_t      w;
  logic         wready;
  axil_b_t      b;
  logic         bready;
  axil_ar_t     ar;
  logic         arready;
  axil_r_t      r;
  logic         rready;
  sample_strm_t sti;
  sample_strm_t sto;
  logic [1:0]   trg_ext;
  stamp_t       cts;
  logic         irq_trg;
  logic         irq_stp;
  logic         trg_swo;

  string       lines[$];               // golden file lines in order
  int          n_lines = 0;
  sample_t     sto_log[$];             // every sample seen on sto
  int          sto_used = 0;           // entries already checked
  int          n_trg = 0;
  int          n_stp = 0;
  int          trg_mark = 0;
  int          stp_mark = 0;
  stamp_t      ext_cts;                // time of the last ext pulse
  logic [31:0] rng = 32'hb760_23f1;

  scope_top scope_top_inst (
    .bus, .rst_n, .aw, .awready, .w, .wready, .b, .bready,
    .ar, .arready, .r, .rready,
    .sti, .trg_ext, .cts, .sto, .irq_trg, .irq_stp, .trg_swo
  );

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  // free running time base with a nonzero hi word
  initial begin
    cts <= 64'h0000_00a5_0000_0000;
    forever begin
      @(posedge bus);
      cts <= cts + 1'b1;
    end
  end

  always @(posedge bus) begin
    if (rst_n && sto.valid) sto_log.push_back(sto.data);
    if (rst_n && irq_trg) n_trg++;
    if (rst_n && irq_stp) n_stp++;
  end

  //////////////////////////////
  // reporting and compares
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input bus_data_t exp, input bus_data_t got);
    if (exp !== got) abort_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic compare_resp(input string name, input bus_resp_t exp, input bus_resp_t got);
    if (exp !== got) abort_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic compare_sample(input string name, input sample_t exp, input sample_t got);
    if (exp !== got) abort_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    if (exp !== got) abort_run($sformatf("mismatch %s exp %h got %h", name, exp, got));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  //////////////////////////////
  // bus and stream drivers
  //////////////////////////////

  task automatic axil_write(input bus_addr_t addr, input bus_data_t data);
    @(posedge bus);
    aw.addr  <= addr;
    aw.valid <= 1'b1;
    w.data   <= data;
    w.strb   <= 4'hf;
    w.valid  <= 1'b1;
    do begin
      @(posedge bus);
    end while (!(awready && wready));  // aw and w go in together
    aw.valid <= 1'b0;
    w.valid  <= 1'b0;
    do begin
      @(posedge bus);
    end while (!b.valid);  // taken here since bready stays high
    compare_resp("b.resp", 2'b00, b.resp);  // okay
  endtask

  task automatic axil_read(input bus_addr_t addr, output bus_data_t data);
    @(posedge bus);
    ar.addr  <= addr;
    ar.valid <= 1'b1;
    do begin
      @(posedge bus);
    end while (!arready);
    ar.valid <= 1'b0;
    do begin
      @(posedge bus);
    end while (!r.valid);
    data = r.data;
    compare_resp("r.resp", 2'b00, r.resp);  // okay
  endtask

  task automatic idle_cycle();
    @(posedge bus);
    rng = lcg_next(rng);
    sti.valid <= 1'b0;
    sti.data  <= sample_t'(rng[31:18]);  // junk on an invalid beat
  endtask

  task automatic play_burst(input int count, input sample_t first, input sample_t step);
    sample_t v;
    v = first;
    repeat (count) begin
      @(posedge bus);
      sti.valid <= 1'b1;
      sti.data  <= v;
      v = v + step;  // wraps like the adc code
    end
    repeat (4) idle_cycle();  // let the pipe drain
  endtask

  task automatic pulse_ext(input logic [1:0] mask);
    @(posedge bus);
    trg_ext <= mask;
    ext_cts = cts + 1'b1;  // cts steps to this at the same edge
    @(posedge bus);
    trg_ext <= 2'b00;
    repeat (3) idle_cycle();
  endtask

  //////////////////////////////
  // result checks
  //////////////////////////////

  task automatic expect_run(input int count, input sample_t first, input sample_t step);
    sample_t v;
    v = first;
    repeat (count) begin
      while (sto_log.size() <= sto_used) @(posedge bus);
      compare_sample("sto.data", v, sto_log[sto_used]);
      sto_used++;
      v = v + step;
    end
  endtask

  task automatic check_irqs(input logic exp_trg, input logic exp_stp);
    int dt;
    int ds;
    repeat (3) @(posedge bus);  // irq lands two cycles after its cause
    dt = n_trg - trg_mark;
    ds = n_stp - stp_mark;
    compare_bit("irq_trg", exp_trg, dt != 0);
    compare_bit("irq_stp", exp_stp, ds != 0);
    if (dt > 1 || ds > 1) abort_run("an interrupt pulsed more than once");
    trg_mark = n_trg;
    stp_mark = n_stp;
  endtask

  // sw trigger copy shows up one cycle after the ctl pulse
  task automatic check_swo(input logic exp);
    @(posedge bus);
    compare_bit("trg_swo", exp, trg_swo);
  endtask

  task automatic check_stamp();
    bus_data_t rd;
    axil_read(`SCOPE_REG_CTS_TRG_LO, rd);
    compare_word("cts_trg[31:0]", ext_cts[31:0], rd);
    axil_read(`SCOPE_REG_CTS_TRG_HI, rd);
    compare_word("cts_trg[63:32]", ext_cts[63:32], rd);
  endtask

  task automatic run_line(input string line);
    byte         kind;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    bus_data_t   rd;
    int          nf;
    kind = line.getc(0);
    f0 = '0;
    f1 = '0;
    f2 = '0;
    nf = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", f0, f1, f2);
    case (kind)
      "#", "\n", " ": ;  // comment or blank
      "W": begin
        axil_write(bus_addr_t'(f0), f1);
        if (bus_addr_t'(f0) == `SCOPE_REG_CTL) check_swo(f1[1]);  // bit 1 is the sw trigger
      end
      "R": begin
        axil_read(bus_addr_t'(f0), rd);
        compare_word($sformatf("rdata[%02h]", f0[6:0]), f1, rd);
      end
      "S": play_burst(int'(f0), sample_t'(f1), sample_t'(f2));
      "O": expect_run(int'(f0), sample_t'(f1), sample_t'(f2));
      "E": pulse_ext(f0[1:0]);
      "I": check_irqs(f0[0], f1[0]);
      "T": check_stamp();
      default: abort_run($sformatf("unknown line in golden file (%0d fields) %s", nf, line));
    endcase
  endtask

  task automatic load_golden();
    int    fd;
    int    n;
    string line;
    fd = $fopen("scope_golden.txt", "r");
    if (fd == 0) abort_run("cannot open scope_golden.txt");
    else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) lines.push_back(line);
      end
      $fclose(fd);
      n_lines = lines.size();
    end
  endtask

  // watchdog scaled to the golden file length
  initial begin
    wait (n_lines != 0);
    repeat (100 * n_lines + 1000) @(posedge bus);
    abort_run("timeout, the DUT stopped answering");
  end

  initial begin
    rst_n   <= 1'b0;
    aw      <= '0;
    w       <= '0;
    bready  <= 1'b1;
    ar      <= '0;
    rready  <= 1'b1;
    sti     <= '0;
    trg_ext <= 2'b00;
    load_golden();
    repeat (10) @(posedge bus);
    rst_n <= 1'b1;
    foreach (lines[i]) run_line(lines[i]);
    repeat (8) @(posedge bus);
    if (sto_log.size() != sto_used) begin
      abort_run($sformatf("%0d samples on sto that nobody expected", sto_log.size() - sto_used));
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* scope_top.sv */
module scope_top
  import scope_bus_pkg::*;
  import scope_dsp_pkg::*;
(
  input  logic         bus,
  input  logic         rst_n,
  // axi4-lite register port
  input  axil_aw_t     aw,
  output logic         awready,
  input  axil_w_t      w,
  output logic         wready,
  output axil_b_t      b,
  input  logic         bready,
  input  axil_ar_t     ar,
  output logic         arready,
  output axil_r_t      r,
  input  logic         rready,
  // streams and triggers
  input  sample_strm_t sti,
  input  logic [1:0]   trg_ext,
  input  stamp_t       cts,       // current time
  output sample_strm_t sto,
  output logic         irq_trg,
  output logic         irq_stp,
  output logic         trg_swo
);

  scope_cfg_t   cfg;
  scope_ctl_t   ctl;
  sample_strm_t std;       // decimated stream
  logic         trg_edge;
  logic         sts_acq;
  logic         sts_trg;
  count_t       sts_pre;
  count_t       sts_pst;
  stamp_t       cts_trg;

  //////////////////////////////
  // register bank, then datapath
  //////////////////////////////

  scope_regs scope_regs_inst (
    .bus, .rst_n, .aw, .awready, .w, .wready, .b, .bready,
    .ar, .arready, .r, .rready,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_trg, .cfg, .ctl
  );

  scope_dec_avg scope_dec_avg_inst (
    .bus, .rst_n, .clr (ctl.rst), .avg (cfg.avg), .dec (cfg.dec),
    .shr (cfg.shr), .sti, .std
  );

  scope_edge scope_edge_inst (
    .bus, .rst_n, .clr (ctl.rst), .edg (cfg.edg), .lvl (cfg.lvl),
    .hst (cfg.hst), .std, .trg_edge
  );

  scope_acq scope_acq_inst (
    .bus, .rst_n, .cfg, .ctl, .std, .trg_edge, .trg_ext, .cts,
    .sto, .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_trg,
    .irq_trg, .irq_stp, .trg_swo
  );

endmodule

/* scope_acq.sv */
module scope_acq
  import scope_dsp_pkg::*;
(
  input  logic         bus,
  input  logic         rst_n,
  input  scope_cfg_t   cfg,
  input  scope_ctl_t   ctl,
  input  sample_strm_t std,
  input  logic         trg_edge,
  input  logic [1:0]   trg_ext,
  input  stamp_t       cts,
  output sample_strm_t sto,
  output logic         sts_acq,
  output logic         sts_trg,
  output count_t       sts_pre,
  output count_t       sts_pst,
  output stamp_t       cts_trg,
  output logic         irq_trg,
  output logic         irq_stp,
  output logic         trg_swo
);

  acq_state_t state;
  trg_sel_t   src;       // masked trigger sources
  logic       trg_go;    // trigger accepted this cycle
  logic       fwd;       // sample goes out next cycle
  logic       trg_seen;  // since last start
  logic       sto_vld;
  sample_t    sto_dat;
  count_t     pre_nxt;
  count_t     pst_nxt;

  always_comb begin
    src     = {trg_ext, trg_edge, ctl.trg} & cfg.trg;
    trg_go  = (state == WAIT) && (|src) && !ctl.rst && !ctl.stp && !ctl.acq;
    fwd     = std.valid && (state != IDLE) && !ctl.rst && !ctl.stp;
    pre_nxt = sts_pre + 1'b1;
    pst_nxt = sts_pst + 1'b1;
  end

  //////////////////////////////
  // acquisition fsm
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      state    <= IDLE;
      sts_pre  <= '0;
      sts_pst  <= '0;
      trg_seen <= 1'b0;
      irq_trg  <= 1'b0;
      irq_stp  <= 1'b0;
      trg_swo  <= 1'b0;
      sto_vld  <= 1'b0;
    end else begin
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
      trg_swo <= ctl.trg;  // sw trigger copy for outside
      sto_vld <= fwd;
      if (ctl.rst) begin
        state    <= IDLE;  // silent, no irq
        trg_seen <= 1'b0;
      end else if (ctl.stp) begin
        if (state != IDLE) irq_stp <= 1'b1;
        state <= IDLE;
      end else if (ctl.acq) begin
        state    <= PRE;
        sts_pre  <= '0;
        sts_pst  <= '0;
        trg_seen <= 1'b0;
      end else begin
        case (state)
          PRE:
            if (sts_pre >= cfg.pre) state <= WAIT;  // pre of 0, or lowered
            else if (std.valid) begin
              sts_pre <= pre_nxt;
              if (pre_nxt >= cfg.pre) state <= WAIT;
            end
          WAIT:
            if (trg_go) begin
              state    <= POST;
              irq_trg  <= 1'b1;
              trg_seen <= 1'b1;
            end
          POST:
            if (sts_pst >= cfg.pst) begin
              state   <= IDLE;
              irq_stp <= 1'b1;
            end else if (std.valid) begin
              sts_pst <= pst_nxt;
              if (pst_nxt >= cfg.pst) begin
                state   <= IDLE;  // last post sample still forwarded
                irq_stp <= 1'b1;
              end
            end
          default: ;
        endcase
      end
    end
  end

  // payload, no reset
  always_ff @(posedge bus) begin
    if (fwd)    sto_dat <= std.data;
    if (trg_go) cts_trg <= cts;  // time of trigger
  end

  assign sto.valid = sto_vld;
  assign sto.data  = sto_dat;
  assign sts_acq   = (state != IDLE);
  assign sts_trg   = trg_seen;

  a_irq_excl: assert property (@(posedge bus) disable iff (!rst_n)
    !(irq_trg && irq_stp));

endmodule

/* scope_edge.sv */
`include "scope_params.svh"

module scope_edge
  import scope_dsp_pkg::*;
(
  input  logic         bus,
  input  logic         rst_n,
  input  logic         clr,
  input  logic         edg,       // 0 rising, 1 falling
  input  sample_t      lvl,
  input  sample_t      hst,
  input  sample_strm_t std,
  output logic         trg_edge
);

  // two guard bits so lvl +/- hst cannot wrap
  localparam int unsigned XW = `SCOPE_DW + 2;
  typedef logic signed [XW-1:0] thr_t;

  thr_t smp;
  thr_t lvl_x;
  thr_t thr_lo;   // arming level, rising
  thr_t thr_hi;   // arming level, falling
  logic arm;
  logic fire;
  logic armed;

  always_comb begin
    smp    = thr_t'(std.data);
    lvl_x  = thr_t'(lvl);
    thr_lo = lvl_x - thr_t'(hst);
    thr_hi = lvl_x + thr_t'(hst);
    if (!edg) begin
      arm  = (smp < thr_lo);
      fire = (smp >= lvl_x);
    end else begin
      arm  = (smp > thr_hi);
      fire = (smp <= lvl_x);
    end
  end

  // armed/disarmed, only moves on valid samples
  always_ff @(posedge bus) begin
    if (!rst_n || clr) begin
      armed    <= 1'b0;
      trg_edge <= 1'b0;
    end else begin
      trg_edge <= std.valid && armed && fire;
      if (std.valid) begin
        if (armed && fire)      armed <= 1'b0;  // fired, wait for re-arm
        else if (!armed && arm) armed <= 1'b1;
      end
    end
  end

endmodule

/* scope_dec_avg.sv */
`include "scope_params.svh"

module scope_dec_avg
  import scope_dsp_pkg::*;
(
  input  logic         bus,
  input  logic         rst_n,
  input  logic         clr,    // control reset, restarts the group
  input  logic         avg,
  input  dec_t         dec,
  input  shift_t       shr,
  input  sample_strm_t sti,
  output sample_strm_t std
);

  // sum of up to 2^17 samples never overflows this
  localparam int unsigned ACW = `SCOPE_DW + `SCOPE_DCW;
  typedef logic signed [ACW-1:0] acc_t;

  dec_t    cnt;      // position in group
  dec_t    lst;      // index of last sample in group
  logic    last;
  acc_t    acc;
  acc_t    sum;      // acc including current sample
  sample_t fst;      // first sample of group
  sample_t fst_nxt;
  logic    vld;
  sample_t dat;

  always_comb begin
    lst     = (dec == '0) ? '0 : dec - 1'b1;  // 0 behaves as 1
    last    = (cnt >= lst);  // >= covers a shrink of dec mid group
    sum     = (cnt == '0) ? acc_t'(sti.data) : acc + acc_t'(sti.data);
    fst_nxt = (cnt == '0) ? sti.data : fst;
  end

  //////////////////////////////
  // group counter
  //////////////////////////////

  always_ff @(posedge bus) begin
    if (!rst_n || clr) begin
      cnt <= '0;
      vld <= 1'b0;
    end else begin
      vld <= sti.valid && last;  // one output per group
      if (sti.valid) cnt <= last ? '0 : cnt + 1'b1;
    end
  end

  // accumulator and output sample
  always_ff @(posedge bus) begin
    if (sti.valid) begin
      acc <= sum;
      fst <= fst_nxt;
      if (last) dat <= avg ? sample_t'(sum >>> shr) : fst_nxt;  // truncate
    end
  end

  assign std.valid = vld;
  assign std.data  = dat;

  a_std_src: assert property (@(posedge bus) disable iff (!rst_n)
    std.valid |-> $past(sti.valid));

endmodule

/* scope_regs.sv */
`include "scope_params.svh"

module scope_regs
  import scope_bus_pkg::*;
  import scope_dsp_pkg::*;
(
  input  logic       bus,
  input  logic       rst_n,
  input  axil_aw_t   aw,
  output logic       awready,
  input  axil_w_t    w,
  output logic       wready,
  output axil_b_t    b,
  input  logic       bready,
  input  axil_ar_t   ar,
  output logic       arready,
  output axil_r_t    r,
  input  logic       rready,
  input  logic       sts_acq,
  input  logic       sts_trg,
  input  count_t     sts_pre,
  input  count_t     sts_pst,
  input  stamp_t     cts_trg,
  output scope_cfg_t cfg,
  output scope_ctl_t ctl
);

  logic      bvld;     // write response pending
  logic      rvld;     // read data pending
  bus_data_t rdata;
  bus_data_t rd_mux;
  logic      wr_go;    // aw and w taken this cycle
  logic      wr_ok;    // ... with full strobes
  logic      rd_go;

  //////////////////////////////
  // write channel
  //////////////////////////////

  assign wr_go   = aw.valid && w.valid && !bvld;
  assign wr_ok   = wr_go && (w.strb == 4'hf);  // partial writes dropped
  assign awready = wr_go;
  assign wready  = wr_go;
  assign b.resp  = AXIL_OKAY;
  assign b.valid = bvld;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      bvld    <= 1'b0;
      ctl     <= '0;
      cfg     <= '0;
      cfg.dec <= dec_t'(1);  // no decimation out of reset
    end else begin
      ctl <= '0;  // pulses last one cycle
      if (bvld && bready) bvld <= 1'b0;
      else if (wr_go)     bvld <= 1'b1;
      if (wr_ok) begin
        case (aw.addr)
          `SCOPE_REG_CTL: begin
            ctl.rst <= w.data[0];
            ctl.trg <= w.data[1];
            ctl.acq <= w.data[2] && !w.data[3];  // stop wins over start
            ctl.stp <= w.data[3];
          end
          `SCOPE_REG_TRG: cfg.trg <= w.data[`SCOPE_TN-1:0];
          `SCOPE_REG_PRE: cfg.pre <= w.data[`SCOPE_CW-1:0];
          `SCOPE_REG_PST: cfg.pst <= w.data[`SCOPE_CW-1:0];
          `SCOPE_REG_LVL: cfg.lvl <= w.data[`SCOPE_DW-1:0];
          `SCOPE_REG_HST: cfg.hst <= w.data[`SCOPE_DW-1:0];
          `SCOPE_REG_EDG: cfg.edg <= w.data[0];
          `SCOPE_REG_AVG: cfg.avg <= w.data[0];
          `SCOPE_REG_DEC: cfg.dec <= w.data[`SCOPE_DCW-1:0];
          `SCOPE_REG_SHR: cfg.shr <= w.data[`SCOPE_DSW-1:0];
          default: ;  // unmapped, ignore
        endcase
      end
    end
  end

  //////////////////////////////
  // read channel
  //////////////////////////////

  assign arready = !rvld;
  assign rd_go   = ar.valid && !rvld;

  always_comb begin
    case (ar.addr)
      `SCOPE_REG_CTL:        rd_mux = {28'h0, !sts_acq, sts_acq, sts_trg, 1'b0};
      `SCOPE_REG_TRG:        rd_mux = {{(32-`SCOPE_TN){1'b0}}, cfg.trg};
      `SCOPE_REG_PRE:        rd_mux = {{(32-`SCOPE_CW){1'b0}}, cfg.pre};
      `SCOPE_REG_PST:        rd_mux = {{(32-`SCOPE_CW){1'b0}}, cfg.pst};
      `SCOPE_REG_STS_PRE:    rd_mux = {{(32-`SCOPE_CW){1'b0}}, sts_pre};
      `SCOPE_REG_STS_PST:    rd_mux = {{(32-`SCOPE_CW){1'b0}}, sts_pst};
      `SCOPE_REG_CTS_TRG_LO: rd_mux = cts_trg[31:0];
      `SCOPE_REG_CTS_TRG_HI: rd_mux = cts_trg[63:32];
      `SCOPE_REG_LVL:        rd_mux = {{(32-`SCOPE_DW){1'b0}}, cfg.lvl};  // raw bits
      `SCOPE_REG_HST:        rd_mux = {{(32-`SCOPE_DW){1'b0}}, cfg.hst};
      `SCOPE_REG_EDG:        rd_mux = {31'h0, cfg.edg};
      `SCOPE_REG_AVG:        rd_mux = {31'h0, cfg.avg};
      `SCOPE_REG_DEC:        rd_mux = {{(32-`SCOPE_DCW){1'b0}}, cfg.dec};
      `SCOPE_REG_SHR:        rd_mux = {{(32-`SCOPE_DSW){1'b0}}, cfg.shr};
      default:               rd_mux = '0;
    endcase
  end

  always_ff @(posedge bus) begin
    if (!rst_n) rvld <= 1'b0;
    else if (rvld && rready) rvld <= 1'b0;
    else if (rd_go) rvld <= 1'b1;
  end

  always_ff @(posedge bus) begin
    if (rd_go) rdata <= rd_mux;  // held until the next address
  end

  assign r.data  = rdata;
  assign r.resp  = AXIL_OKAY;
  assign r.valid = rvld;

  // responses stay put until the master takes them
  a_b_hold: assert property (@(posedge bus) disable iff (!rst_n)
    b.valid && !bready |=> b.valid);
  a_r_hold: assert property (@(posedge bus) disable iff (!rst_n)
    r.valid && !rready |=> r.valid && $stable(r.data));
  a_ctl_excl: assert property (@(posedge bus) disable iff (!rst_n)
    !(ctl.acq && ctl.stp));

endmodule

/* scope_dsp_pkg.sv */
`include "scope_params.svh"

package scope_dsp_pkg;

  typedef logic signed [`SCOPE_DW-1:0] sample_t;   // adc code, two's complement
  typedef logic [`SCOPE_CW-1:0]        count_t;    // pre/post sample count
  typedef logic [`SCOPE_DCW-1:0]       dec_t;      // decimation factor
  typedef logic [`SCOPE_DSW-1:0]       shift_t;    // right shift after summing
  typedef logic [`SCOPE_TW-1:0]        stamp_t;    // free running time
  // bit 0 sw, bit 1 edge, bits 3:2 external lines
  typedef logic [`SCOPE_TN-1:0]        trg_sel_t;

  // sample stream, no ready since the adc never stalls
  typedef struct packed {
    logic    valid;
    sample_t data;
  } sample_strm_t;

  typedef struct packed {
    trg_sel_t trg;  // trigger source mask
    count_t   pre;  // samples before trigger
    count_t   pst;  // samples after trigger
    sample_t  lvl;  // edge level
    sample_t  hst;  // hysteresis
    logic     edg;  // 0 rising, 1 falling
    logic     avg;  // sum group instead of picking first
    dec_t     dec;  // group size, 0 acts as 1
    shift_t   shr;
  } scope_cfg_t;

  // single cycle pulses from a CTL write
  typedef struct packed {
    logic rst;
    logic trg;
    logic acq;
    logic stp;
  } scope_ctl_t;

  typedef enum logic [1:0] {IDLE, PRE, WAIT, POST} acq_state_t;

endpackage

/* scope_bus_pkg.sv */
`include "scope_params.svh"

package scope_bus_pkg;

  // plain bus words
  typedef logic [`SCOPE_AW-1:0] bus_addr_t;  // byte address
  typedef logic [31:0]          bus_data_t;
  typedef logic [3:0]           bus_strb_t;  // one bit per byte lane
  typedef logic [1:0]           bus_resp_t;

  localparam bus_resp_t AXIL_OKAY = 2'b00;  // only response ever returned

  //////////////////////////////
  // axi4-lite channels, ready travels on its own
  //////////////////////////////

  typedef struct packed {
    bus_addr_t addr;
    logic      valid;
  } axil_aw_t;

  typedef struct packed {
    bus_data_t data;
    bus_strb_t strb;
    logic      valid;
  } axil_w_t;

  typedef struct packed {
    bus_resp_t resp;
    logic      valid;
  } axil_b_t;

  typedef struct packed {
    bus_addr_t addr;
    logic      valid;
  } axil_ar_t;

  typedef struct packed {
    bus_data_t data;
    bus_resp_t resp;
    logic      valid;
  } axil_r_t;

endpackage

/* scope_params.svh */
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

// datapath widths
`define SCOPE_DW   14   // adc sample
`define SCOPE_CW   17   // pre/post counters
`define SCOPE_DCW  17   // decimation factor
`define SCOPE_DSW  4    // averaging shift
`define SCOPE_TW   64   // timestamp
`define SCOPE_TN   4    // trigger select mask
`define SCOPE_AW   7    // register byte address

// register map, byte offsets
`define SCOPE_REG_CTL         7'h00  // control pulses / status word
`define SCOPE_REG_TRG         7'h08
`define SCOPE_REG_PRE         7'h10
`define SCOPE_REG_PST         7'h14
`define SCOPE_REG_STS_PRE     7'h18
`define SCOPE_REG_STS_PST     7'h1c
`define SCOPE_REG_CTS_TRG_LO  7'h28
`define SCOPE_REG_CTS_TRG_HI  7'h2c
`define SCOPE_REG_LVL         7'h50
`define SCOPE_REG_HST         7'h54
`define SCOPE_REG_EDG         7'h58
`define SCOPE_REG_AVG         7'h60
`define SCOPE_REG_DEC         7'h64
`define SCOPE_REG_SHR         7'h68
`endif
